// File: logic/vfe_defines.svh
/*
 * Data widths, pipeline latency and CSC fixed-point constants
 * for the video front end
 */

`ifndef VFE_DEFINES_SVH
`define VFE_DEFINES_SVH

// Sample and counter widths
`define VFE_PIX_W       8
`define VFE_HCNT_W      12
`define VFE_VCNT_W      11

// Signed intermediate colour value and coefficient widths
`define VFE_CSC_W       11
`define VFE_COEF_W      18
`define VFE_CSC_SHIFT   15

// Input to output latency in pixel clocks
`define VFE_PIPE_LAT    5

// BT.601 YCbCr to RGB coefficients, Q2.15
`define VFE_C601_RCR    18'h0B395
`define VFE_C601_GCB    18'h02C08
`define VFE_C601_GCR    18'h05B64
`define VFE_C601_BCB    18'h0E2F1

// BT.709 YCbCr to RGB coefficients, Q2.15
`define VFE_C709_RCR    18'h0C8F9
`define VFE_C709_GCB    18'h017EF
`define VFE_C709_GCR    18'h03BB2
`define VFE_C709_BCB    18'h0ED84

`endif

// File: logic/vfe_pkg.sv
/*
 * Shared types of the video front end: width typedefs, the sample,
 * configuration and timing structs, and the colour standard enum
 */

`default_nettype none

`include "vfe_defines.svh"

package vfe_pkg;

    typedef logic [`VFE_PIX_W-1:0]         pix_t;
    typedef logic [`VFE_HCNT_W-1:0]        hcnt_t;
    typedef logic [`VFE_VCNT_W-1:0]        vcnt_t;
    typedef logic signed [`VFE_CSC_W-1:0]  csc_t;
    typedef logic signed [`VFE_COEF_W-1:0] coef_t;

    typedef struct packed {
        pix_t r;
        pix_t g;
        pix_t b;
    } rgb_s;

    // Static timing description, polarity bit set means active high input
    typedef struct packed {
        hcnt_t h_total;
        hcnt_t h_active;
        hcnt_t h_synclen;
        hcnt_t h_backporch;
        vcnt_t v_active;
        vcnt_t v_synclen;
        vcnt_t v_backporch;
        logic  hs_pol;
        logic  vs_pol;
    } timing_cfg_s;

    typedef struct packed {
        logic  hsync;
        logic  vsync;
        logic  de;
        hcnt_t xpos;
        vcnt_t ypos;
        logic  frame_change;
    } timing_s;

    typedef enum logic {
        CSC_BT601 = 1'b0,
        CSC_BT709 = 1'b1
    } csc_std_e;

endpackage

`default_nettype wire

// File: logic/sync_timing_gen.sv
/*
 * Sync polarity correction, horizontal and vertical counters and
 * regenerated HSYNC, VSYNC, DE and active-area position
 */

`default_nettype none

module sync_timing_gen
    import vfe_pkg::*;
(
    input  wire         PCLK_i,
    input  wire         arst_n_i,
    input  wire         hs_i,
    input  wire         vs_i,
    input  timing_cfg_s cfg_i,
    output timing_s     timing_o
);

    logic  hs_act;
    logic  vs_act;
    logic  hs_prev;
    logic  vs_prev;
    logic  h_edge;
    logic  vs_edge;
    logic  v_pend;
    logic  de_next;
    hcnt_t h_cnt;
    hcnt_t h_start;
    hcnt_t h_end;
    vcnt_t v_cnt;
    vcnt_t v_start;
    vcnt_t v_end;

    // Normalise both syncs to active high
    assign hs_act = cfg_i.hs_pol ? hs_i : ~hs_i;
    assign vs_act = cfg_i.vs_pol ? vs_i : ~vs_i;

    assign h_edge  = hs_prev & ~hs_act;
    assign vs_edge = vs_prev & ~vs_act;

    // Active window boundaries
    assign h_start = cfg_i.h_synclen + cfg_i.h_backporch;
    assign h_end   = h_start + cfg_i.h_active;
    assign v_start = cfg_i.v_synclen + cfg_i.v_backporch;
    assign v_end   = v_start + cfg_i.v_active;

    assign de_next = (h_cnt >= h_start) && (h_cnt < h_end) &&
                     (v_cnt >= v_start) && (v_cnt < v_end);

    always_ff @(posedge PCLK_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            hs_prev  <= 1'b0;
            vs_prev  <= 1'b0;
            v_pend   <= 1'b0;
            h_cnt    <= '0;
            v_cnt    <= '0;
            timing_o <= '0;
        end else begin
            hs_prev <= hs_act;
            vs_prev <= vs_act;

            timing_o.de           <= de_next;
            timing_o.xpos         <= h_cnt - h_start;
            timing_o.ypos         <= v_cnt - v_start;
            timing_o.frame_change <= 1'b0;

            if (h_edge) begin
                h_cnt          <= '0;
                timing_o.hsync <= 1'b0;

                // Vertical detection lags one line, so the new frame starts at line 1
                if (v_pend) begin
                    v_cnt                 <= vcnt_t'(1);
                    v_pend                <= 1'b0;
                    timing_o.vsync        <= 1'b0;
                    timing_o.frame_change <= 1'b1;
                end else begin
                    v_cnt <= v_cnt + 1'b1;
                    if (v_cnt == cfg_i.v_synclen - 1'b1)
                        timing_o.vsync <= 1'b1;
                end
            end else begin
                h_cnt <= h_cnt + 1'b1;
                if (h_cnt == cfg_i.h_synclen - 1'b1)
                    timing_o.hsync <= 1'b1;
            end

            // Arm the frame start for the next line edge
            if (vs_edge)
                v_pend <= 1'b1;
        end
    end

    a_frame_change_pulse: assert property (@(posedge PCLK_i) disable iff (!arst_n_i)
        timing_o.frame_change |=> !timing_o.frame_change)
        else $error("frame_change held high for more than one cycle");

    a_de_in_line: assert property (@(posedge PCLK_i) disable iff (!arst_n_i)
        de_next |-> (h_cnt < cfg_i.h_total))
        else $error("DE window reaches past h_total");

endmodule

`default_nettype wire

// File: logic/ycbcr_rgb_csc.sv
/*
 * Five-stage YCbCr to RGB converter with BT.601/BT.709 coefficients,
 * output clamping and a latency-matched bypass
 */

`default_nettype none

`include "vfe_defines.svh"

module ycbcr_rgb_csc
    import vfe_pkg::*;
(
    input  wire      PCLK_i,
    input  wire      arst_n_i,
    input  wire      csc_en_i,
    input  csc_std_e csc_std_i,
    input  rgb_s     pix_i,
    output rgb_s     pix_o
);

    localparam int PROD_W = `VFE_CSC_W + `VFE_COEF_W;

    typedef struct packed {
        coef_t r_cr;
        coef_t g_cb;
        coef_t g_cr;
        coef_t b_cb;
    } coef_set_s;

    typedef struct packed {
        csc_t r_cr;
        csc_t g_cb;
        csc_t g_cr;
        csc_t b_cb;
    } csc_terms_s;

    csc_t       y_s1;
    csc_t       cb_s1;
    csc_t       cr_s1;
    coef_set_s  coef_s1;
    coef_set_s  coef_sel;
    csc_t       y_s2;
    csc_terms_s terms_s2;
    csc_t       y_s3;
    csc_terms_s terms_s3;
    csc_t       r_sum;
    csc_t       g_sum;
    csc_t       b_sum;
    rgb_s       rgb_s4;
    rgb_s       byp_q [4];

    // Signed product scaled back to the intermediate width
    function automatic csc_t mul_shift(csc_t a, coef_t c);
        logic signed [PROD_W-1:0] prod;
        prod = a * c;
        return prod[`VFE_CSC_SHIFT +: `VFE_CSC_W];
    endfunction

    function automatic pix_t clamp(csc_t s);
        if (s < 0)
            return '0;
        else if (s > 255)
            return '1;
        return s[`VFE_PIX_W-1:0];
    endfunction

    always_comb begin
        if (csc_std_i == CSC_BT709) begin
            coef_sel.r_cr = coef_t'(`VFE_C709_RCR);
            coef_sel.g_cb = coef_t'(`VFE_C709_GCB);
            coef_sel.g_cr = coef_t'(`VFE_C709_GCR);
            coef_sel.b_cb = coef_t'(`VFE_C709_BCB);
        end else begin
            coef_sel.r_cr = coef_t'(`VFE_C601_RCR);
            coef_sel.g_cb = coef_t'(`VFE_C601_GCB);
            coef_sel.g_cr = coef_t'(`VFE_C601_GCR);
            coef_sel.b_cb = coef_t'(`VFE_C601_BCB);
        end
    end

    assign r_sum = y_s3 + terms_s3.r_cr;
    assign g_sum = y_s3 - terms_s3.g_cr - terms_s3.g_cb;
    assign b_sum = y_s3 + terms_s3.b_cb;

    always_ff @(posedge PCLK_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            y_s1     <= '0;
            cb_s1    <= '0;
            cr_s1    <= '0;
            coef_s1  <= '0;
            y_s2     <= '0;
            terms_s2 <= '0;
            y_s3     <= '0;
            terms_s3 <= '0;
            rgb_s4   <= '0;
            pix_o    <= '0;
            for (int i = 0; i < 4; i++)
                byp_q[i] <= '0;
        end else begin
            // Stage 1: Y on G, chroma on B and R with the 128 offset removed
            y_s1    <= csc_t'(pix_i.g);
            cb_s1   <= csc_t'(pix_i.b) - csc_t'(128);
            cr_s1   <= csc_t'(pix_i.r) - csc_t'(128);
            coef_s1 <= coef_sel;

            // Stage 2: chroma products
            y_s2          <= y_s1;
            terms_s2.r_cr <= mul_shift(cr_s1, coef_s1.r_cr);
            terms_s2.g_cb <= mul_shift(cb_s1, coef_s1.g_cb);
            terms_s2.g_cr <= mul_shift(cr_s1, coef_s1.g_cr);
            terms_s2.b_cb <= mul_shift(cb_s1, coef_s1.b_cb);

            // Stage 3: align Y with the products
            y_s3     <= y_s2;
            terms_s3 <= terms_s2;

            // Stage 4: sums with saturation
            rgb_s4.r <= clamp(r_sum);
            rgb_s4.g <= clamp(g_sum);
            rgb_s4.b <= clamp(b_sum);

            // Unconverted sample follows the same number of stages
            byp_q[0] <= pix_i;
            for (int i = 1; i < 4; i++)
                byp_q[i] <= byp_q[i-1];

            // Stage 5: output select
            pix_o <= csc_en_i ? rgb_s4 : byp_q[3];
        end
    end

    a_clamp_r: assert property (@(posedge PCLK_i) disable iff (!arst_n_i)
        (r_sum < 0 || r_sum > 255) |=> (rgb_s4.r == '0 || rgb_s4.r == '1))
        else $error("R channel not saturated");

    a_clamp_g: assert property (@(posedge PCLK_i) disable iff (!arst_n_i)
        (g_sum < 0 || g_sum > 255) |=> (rgb_s4.g == '0 || rgb_s4.g == '1))
        else $error("G channel not saturated");

    a_clamp_b: assert property (@(posedge PCLK_i) disable iff (!arst_n_i)
        (b_sum < 0 || b_sum > 255) |=> (rgb_s4.b == '0 || rgb_s4.b == '1))
        else $error("B channel not saturated");

endmodule

`default_nettype wire

// File: logic/timing_delay_line.sv
/*
 * Shift register that delays the timing struct to match the colour path
 */

`default_nettype none

module timing_delay_line
    import vfe_pkg::*;
#(
    parameter int DEPTH = 4
) (
    input  wire     PCLK_i,
    input  wire     arst_n_i,
    input  timing_s timing_i,
    output timing_s timing_o
);

    timing_s pipe_q [DEPTH];

    if (DEPTH < 1) begin : g_depth_check
        $error("timing_delay_line needs DEPTH of at least 1");
    end

    // Sync outputs must come out of reset inactive, so every stage is cleared
    always_ff @(posedge PCLK_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < DEPTH; i++)
                pipe_q[i] <= '0;
        end else begin
            pipe_q[0] <= timing_i;
            for (int i = 1; i < DEPTH; i++)
                pipe_q[i] <= pipe_q[i-1];
        end
    end

    assign timing_o = pipe_q[DEPTH-1];

endmodule

`default_nettype wire

// File: logic/video_frontend_top.sv
/*
 * Video front end top level: timing regeneration, timing delay
 * and colour space conversion
 */

`default_nettype none

`include "vfe_defines.svh"

module video_frontend_top
    import vfe_pkg::*;
(
    input  wire         PCLK_i,
    input  wire         arst_n_i,
    input  rgb_s        raw_rgb_i,
    input  wire         hs_i,
    input  wire         vs_i,
    input  timing_cfg_s cfg_i,
    input  wire         csc_en_i,
    input  csc_std_e    csc_std_i,
    output rgb_s        rgb_o,
    output timing_s     timing_o
);

    timing_s stage1_timing;

    // Regenerated timing leaves this block one cycle after sampling
    sync_timing_gen i_sync_timing_gen (
        .PCLK_i   (PCLK_i),
        .arst_n_i (arst_n_i),
        .hs_i     (hs_i),
        .vs_i     (vs_i),
        .cfg_i    (cfg_i),
        .timing_o (stage1_timing)
    );

    // Remaining stages so timing lines up with the converter output
    timing_delay_line #(
        .DEPTH (`VFE_PIPE_LAT - 1)
    ) i_timing_delay_line (
        .PCLK_i   (PCLK_i),
        .arst_n_i (arst_n_i),
        .timing_i (stage1_timing),
        .timing_o (timing_o)
    );

    ycbcr_rgb_csc i_ycbcr_rgb_csc (
        .PCLK_i    (PCLK_i),
        .arst_n_i  (arst_n_i),
        .csc_en_i  (csc_en_i),
        .csc_std_i (csc_std_i),
        .pix_i     (raw_rgb_i),
        .pix_o     (rgb_o)
    );

endmodule

`default_nettype wire

// File: dv/tb_video_frontend.sv
/*
 * Testbench for the video front end: CSC stimulus table with a
 * reference model, and a small frame for the timing regeneration
 */

`default_nettype none

`include "vfe_defines.svh"

module tb_video_frontend
    import vfe_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_HALF      = 50;
    localparam int RESET_CYCLES  = 5;
    localparam int N_RAND        = 16;
    localparam int GROUP_LEN     = 3 + N_RAND;
    localparam int N_ENTRIES     = 3 * GROUP_LEN;
    localparam int LAT           = `VFE_PIPE_LAT;
    // Small frame used for the timing checks
    localparam int H_TOTAL       = 40;
    localparam int H_SYNC        = 4;
    localparam int H_BP          = 6;
    localparam int H_ACTIVE      = 24;
    localparam int V_SYNC        = 2;
    localparam int V_BP          = 3;
    localparam int V_ACTIVE      = 8;
    localparam int HS_PULSE      = 4;
    localparam int VS_LINES      = 2;
    localparam int FRAME_LEN     = H_TOTAL * 16;
    localparam int N_FRAMES      = 3;
    localparam int TIMING_CYCLES = (N_FRAMES + 1) * FRAME_LEN;

    typedef struct packed {
        logic     csc_en;
        csc_std_e csc_std;
        rgb_s     pix;
    } stim_s;

    logic        PCLK_i = 1'b0;
    logic        arst_n_i;
    rgb_s        raw_rgb_i;
    logic        hs_i;
    logic        vs_i;
    timing_cfg_s cfg_i;
    logic        csc_en_i;
    csc_std_e    csc_std_i;
    rgb_s        rgb_o;
    timing_s     timing_o;
    int          seed;

    // Stimulus table as parallel queues
    string tbl_name [$];
    stim_s tbl_stim [$];
    rgb_s  tbl_exp [$];

    video_frontend_top i_video_frontend_top (
        .PCLK_i    (PCLK_i),
        .arst_n_i  (arst_n_i),
        .raw_rgb_i (raw_rgb_i),
        .hs_i      (hs_i),
        .vs_i      (vs_i),
        .cfg_i     (cfg_i),
        .csc_en_i  (csc_en_i),
        .csc_std_i (csc_std_i),
        .rgb_o     (rgb_o),
        .timing_o  (timing_o)
    );

    always #(CLK_HALF) PCLK_i = ~PCLK_i;

    task automatic check_value(input string name, input logic [31:0] exp_v,
                               input logic [31:0] act_v);
        if (exp_v !== act_v) begin
            $display("ERR %s expected 0x%0h actual 0x%0h", name, exp_v, act_v);
            $display("Regression failed");
            $fatal(1, "Value mismatch in %s", name);
        end
    endtask

    // Chroma product scaled by the fraction bits, kept to the intermediate width
    function automatic int chroma_term(input int c, input int coef);
        int                           prod;
        logic signed [`VFE_CSC_W-1:0] term;
        prod = c * coef;
        term = prod >>> `VFE_CSC_SHIFT;
        return int'(term);
    endfunction

    function automatic pix_t saturate(input int v);
        if (v < 0)
            return 8'd0;
        if (v > 255)
            return 8'd255;
        return pix_t'(v);
    endfunction

    function automatic rgb_s model_rgb(input stim_s s);
        int   y;
        int   cb;
        int   cr;
        int   k_rcr;
        int   k_gcb;
        int   k_gcr;
        int   k_bcb;
        rgb_s out;
        if (!s.csc_en)
            return s.pix;
        y  = int'(s.pix.g);
        cb = int'(s.pix.b) - 128;
        cr = int'(s.pix.r) - 128;
        if (s.csc_std == CSC_BT709) begin
            k_rcr = `VFE_C709_RCR;
            k_gcb = `VFE_C709_GCB;
            k_gcr = `VFE_C709_GCR;
            k_bcb = `VFE_C709_BCB;
        end else begin
            k_rcr = `VFE_C601_RCR;
            k_gcb = `VFE_C601_GCB;
            k_gcr = `VFE_C601_GCR;
            k_bcb = `VFE_C601_BCB;
        end
        out.r = saturate(y + chroma_term(cr, k_rcr));
        out.g = saturate(y - chroma_term(cr, k_gcr) - chroma_term(cb, k_gcb));
        out.b = saturate(y + chroma_term(cb, k_bcb));
        return out;
    endfunction

    task automatic add_entry(input string name, input logic en, input csc_std_e std,
                             input rgb_s pix);
        stim_s s;
        s.csc_en  = en;
        s.csc_std = std;
        s.pix     = pix;
        tbl_name.push_back(name);
        tbl_stim.push_back(s);
        tbl_exp.push_back(model_rgb(s));
    endtask

    task automatic build_table();
        string       tags [3];
        rgb_s        rand_pix [N_RAND];
        logic [31:0] r32;
        logic        en;
        csc_std_e    std;
        tags[0] = "bt601";
        tags[1] = "bt709";
        tags[2] = "bypass";
        for (int i = 0; i < N_RAND; i++) begin
            r32         = $random(seed);
            rand_pix[i] = r32[23:0];
        end
        // One group per mode, same samples in each
        for (int m = 0; m < 3; m++) begin
            en  = (m != 2);
            std = (m == 1) ? CSC_BT709 : CSC_BT601;
            add_entry({tags[m], "_black"}, en, std, 24'h000000);
            add_entry({tags[m], "_white"}, en, std, 24'hFFFFFF);
            add_entry({tags[m], "_mid"}, en, std, 24'h808080);
            for (int i = 0; i < N_RAND; i++)
                add_entry($sformatf("%s_rand%0d", tags[m], i), en, std, rand_pix[i]);
        end
    endtask

    // Streams one group back to back, output checked LAT cycles after each drive
    task automatic stream_group(input int lo, input int hi);
        for (int i = 0; i < hi - lo + LAT; i++) begin
            @(posedge PCLK_i);
            if (i < hi - lo) begin
                raw_rgb_i <= tbl_stim[lo + i].pix;
                csc_en_i  <= tbl_stim[lo + i].csc_en;
                csc_std_i <= tbl_stim[lo + i].csc_std;
            end
            @(negedge PCLK_i);
            if (i >= LAT)
                check_value(tbl_name[lo + i - LAT], 32'(tbl_exp[lo + i - LAT]), 32'(rgb_o));
        end
    endtask

    task automatic run_frames();
        timing_s t;
        timing_s prev;
        int      de_run;
        int      last_x;
        int      exp_y;
        int      hs_low;
        int      vs_low;
        int      fc_count;
        bit      hs_armed;
        bit      vs_armed;
        bit      seen_frame;
        de_run     = 0;
        last_x     = 0;
        exp_y      = 0;
        hs_low     = 0;
        vs_low     = 0;
        fc_count   = 0;
        hs_armed   = 0;
        vs_armed   = 0;
        seen_frame = 0;
        prev       = timing_o;
        for (int c = 0; c < TIMING_CYCLES; c++) begin
            @(posedge PCLK_i);
            // HS is active low here, VS active high
            hs_i <= ((c % H_TOTAL) < HS_PULSE) ? 1'b0 : 1'b1;
            vs_i <= ((c % FRAME_LEN) < VS_LINES * H_TOTAL) ? 1'b1 : 1'b0;
            @(negedge PCLK_i);
            t = timing_o;
            if (t.de) begin
                if (de_run == 0) begin
                    check_value("first xpos of line", 0, 32'(t.xpos));
                    if (seen_frame) begin
                        check_value("ypos order", 32'(exp_y), 32'(t.ypos));
                        exp_y++;
                    end
                end else begin
                    check_value("xpos step", 32'(last_x + 1), 32'(t.xpos));
                end
                last_x = int'(t.xpos);
                de_run++;
            end else if (de_run != 0) begin
                check_value("de run length", H_ACTIVE, 32'(de_run));
                de_run = 0;
            end
            if (!t.hsync && prev.hsync) begin
                check_value("hsync fall phase", HS_PULSE + LAT, 32'(c % H_TOTAL));
                hs_low   = 0;
                hs_armed = 1;
            end
            if (!t.hsync)
                hs_low++;
            else if (!prev.hsync && hs_armed)
                check_value("hsync low length", H_SYNC, 32'(hs_low));
            if (t.frame_change) begin
                check_value("frame_change width", 0, 32'(prev.frame_change));
                check_value("vsync at frame start", 0, 32'(t.vsync));
                if (seen_frame)
                    check_value("de lines per frame", V_ACTIVE, 32'(exp_y));
                seen_frame = 1;
                exp_y      = 0;
                vs_low     = 0;
                vs_armed   = 1;
                fc_count++;
            end
            if (!t.vsync)
                vs_low++;
            else if (!prev.vsync && vs_armed)
                check_value("vsync low length", (V_SYNC - 1) * H_TOTAL, 32'(vs_low));
            prev = t;
        end
        check_value("frame count", N_FRAMES + 1, 32'(fc_count));
    endtask

    initial begin
        int limit_cycles;
        limit_cycles = RESET_CYCLES + N_ENTRIES + 3 * LAT + TIMING_CYCLES + 50;
        repeat (limit_cycles) @(posedge PCLK_i);
        $display("Simulation timed out after %0d cycles", limit_cycles);
        $display("Regression failed");
        $fatal(1, "Watchdog expired");
    end

    initial begin
        seed      = 46;
        arst_n_i  = 1'b0;
        raw_rgb_i = '0;
        hs_i      = 1'b1;
        vs_i      = 1'b0;
        csc_en_i  = 1'b0;
        csc_std_i = CSC_BT601;
        cfg_i             = '0;
        cfg_i.h_total     = hcnt_t'(H_TOTAL);
        cfg_i.h_active    = hcnt_t'(H_ACTIVE);
        cfg_i.h_synclen   = hcnt_t'(H_SYNC);
        cfg_i.h_backporch = hcnt_t'(H_BP);
        cfg_i.v_active    = vcnt_t'(V_ACTIVE);
        cfg_i.v_synclen   = vcnt_t'(V_SYNC);
        cfg_i.v_backporch = vcnt_t'(V_BP);
        cfg_i.hs_pol      = 1'b0;
        cfg_i.vs_pol      = 1'b1;
        build_table();
        repeat (RESET_CYCLES) @(posedge PCLK_i);
        arst_n_i <= 1'b1;
        for (int g = 0; g < 3; g++)
            stream_group(g * GROUP_LEN, (g + 1) * GROUP_LEN);
        run_frames();
        $display("Regression passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
+incdir+logic
logic/vfe_pkg.sv
logic/sync_timing_gen.sv
logic/ycbcr_rgb_csc.sv
logic/timing_delay_line.sv
logic/video_frontend_top.sv
dv/tb_video_frontend.sv

// File: run_sim.sh
#!/bin/sh
# Builds the video front end testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f list.f \
    --top-module tb_video_frontend -o tb_video_frontend
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_video_frontend
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit $status
fi

exit 0
